/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_csr
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the pass line in the output decides the exit status
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* bench/csr_model.svh */
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// writable field masks
localparam csr_pkg::csr_data_t CRMD_WMASK   = 32'h0000_001f;
localparam csr_pkg::csr_data_t PRMD_WMASK   = 32'h0000_0007;
localparam csr_pkg::csr_data_t ECFG_WMASK   = 32'h0000_1bff;
localparam csr_pkg::csr_data_t EENTRY_WMASK = 32'hffff_ffc0;

csr_pkg::csr_data_t exp_crmd;
csr_pkg::csr_data_t exp_prmd;
csr_pkg::csr_data_t exp_ecfg;
csr_pkg::csr_data_t exp_era;
csr_pkg::csr_data_t exp_badv;
csr_pkg::csr_data_t exp_eentry;
csr_pkg::csr_data_t exp_tid;
csr_pkg::csr_data_t exp_tcfg;
csr_pkg::csr_data_t exp_save [SAVE_NUM];
logic [1:0]         exp_is_sw;
logic [7:0]         exp_is_hw;
logic               exp_ti;
csr_pkg::ecode_t    exp_ecode;
csr_pkg::esubcode_t exp_esub;

// era, badv, eentry and save have no reset value
function void clear_state();
  exp_crmd  = 32'h0000_0008;
  exp_prmd  = '0;
  exp_ecfg  = '0;
  exp_tid   = '0;
  exp_tcfg  = '0;
  exp_is_sw = '0;
  exp_is_hw = '0;
  exp_ti    = 1'b0;
  exp_ecode = '0;
  exp_esub  = '0;
endfunction

function csr_pkg::csr_data_t estat_value();
  return {1'b0, exp_esub, exp_ecode, 4'b0000, exp_ti, 1'b0, exp_is_hw, exp_is_sw};
endfunction

function logic int_pending();
  csr_pkg::csr_data_t estat;
  estat = estat_value();
  return exp_crmd[csr_pkg::CRMD_IE] && ((exp_ecfg[12:0] & estat[12:0]) != 13'd0);
endfunction

function void apply_write(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t data);
  case (addr)
    csr_pkg::CRMD:   exp_crmd = data & CRMD_WMASK;
    csr_pkg::PRMD:   exp_prmd = data & PRMD_WMASK;
    csr_pkg::ECFG:   exp_ecfg = data & ECFG_WMASK;
    csr_pkg::ESTAT:  exp_is_sw = data[1:0];
    csr_pkg::ERA:    exp_era = data;
    csr_pkg::BADV:   exp_badv = data;
    csr_pkg::EENTRY: exp_eentry = data & EENTRY_WMASK;
    csr_pkg::TID:    exp_tid = data;
    csr_pkg::TCFG:   exp_tcfg = data;
    csr_pkg::TICLR: begin
      if (data[csr_pkg::TICLR_CLR]) begin
        exp_ti = 1'b0;
      end
    end
    default: begin
      for (int i = 0; i < SAVE_NUM; i++) begin
        if (addr == csr_pkg::csr_addr_t'(csr_pkg::SAVE0 + i)) begin
          exp_save[i] = data;
        end
      end
    end
  endcase
endfunction

// tval is tracked by the timer tests themselves
function csr_pkg::csr_data_t expected_read(input csr_pkg::csr_addr_t addr);
  csr_pkg::csr_data_t val;
  val = '0;
  case (addr)
    csr_pkg::CRMD:   val = exp_crmd;
    csr_pkg::PRMD:   val = exp_prmd;
    csr_pkg::ECFG:   val = exp_ecfg;
    csr_pkg::ESTAT:  val = estat_value();
    csr_pkg::ERA:    val = exp_era;
    csr_pkg::BADV:   val = exp_badv;
    csr_pkg::EENTRY: val = exp_eentry;
    csr_pkg::TID:    val = exp_tid;
    csr_pkg::TCFG:   val = exp_tcfg;
    default: begin
      for (int i = 0; i < SAVE_NUM; i++) begin
        if (addr == csr_pkg::csr_addr_t'(csr_pkg::SAVE0 + i)) begin
          val = exp_save[i];
        end
      end
    end
  endcase
  return val;
endfunction

// plv and ie move into prmd
function void take_exception(input csr_pkg::csr_data_t era, input csr_pkg::ecode_t code,
                             input csr_pkg::esubcode_t sub, input csr_pkg::csr_data_t badv);
  exp_prmd  = exp_crmd & PRMD_WMASK;
  exp_crmd  = exp_crmd & ~PRMD_WMASK;
  exp_era   = era;
  exp_ecode = code;
  exp_esub  = sub;
  exp_badv  = badv;
endfunction

function void restore_mode();
  exp_crmd = (exp_crmd & ~PRMD_WMASK) | (exp_prmd & PRMD_WMASK);
endfunction

`endif

/* bench/tb_csr.sv */
`timescale 1ns/100ps

module tb_csr;

  localparam int SAVE_NUM   = 4;
  localparam int RW_NUM     = 7 + SAVE_NUM;
  localparam int RW_ROUNDS  = 60;
  localparam int INT_ROUNDS = 40;
  // all tests need roughly 900 cycles
  localparam int MAX_CYCLES = 4000;

  logic                          clk;
  logic                          resetn;
  csr_pkg::csr_addr_t            csr_raddr;
  csr_pkg::csr_data_t            csr_rdata;
  logic                          csr_wen;
  csr_pkg::csr_addr_t            csr_waddr;
  csr_pkg::csr_data_t            csr_wdata;
  logic [csr_pkg::INT_LINES-1:0] interrupt;
  logic                          excp;
  logic                          ertn;
  csr_pkg::csr_data_t            excp_era;
  csr_pkg::ecode_t               excp_code;
  csr_pkg::esubcode_t            excp_subcode;
  logic                          excp_addr;
  csr_pkg::csr_data_t            badv_addr;
  logic                          has_int;
  csr_pkg::plv_t                 plv;
  csr_pkg::csr_data_t            eentry_out;
  csr_pkg::csr_data_t            era_out;
  csr_pkg::csr_data_t            tid_out;
  logic [63:0]                   timer_64;

  integer             seed;
  int                 errors;
  int                 checks;
  int                 cycles;
  csr_pkg::csr_addr_t rw_addrs [RW_NUM];

  `include "csr_model.svh"

  csr_regfile #(.SAVE_NUM(SAVE_NUM)) UUT (
    .clk(clk), .resetn(resetn), .csr_raddr(csr_raddr), .csr_rdata(csr_rdata),
    .csr_wen(csr_wen), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata),
    .interrupt(interrupt), .excp(excp), .ertn(ertn), .excp_era(excp_era),
    .excp_code(excp_code), .excp_subcode(excp_subcode), .excp_addr(excp_addr),
    .badv_addr(badv_addr), .has_int(has_int), .plv(plv), .eentry_out(eentry_out),
    .era_out(era_out), .tid_out(tid_out), .timer_64(timer_64)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Error: timeout after %0d cycles, %0d errors so far", cycles, errors);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function csr_pkg::csr_data_t draw_random();
    return $random(seed);
  endfunction

  task automatic check_word(input string name, input csr_pkg::csr_data_t expv,
                            input csr_pkg::csr_data_t actv);
    checks = checks + 1;
    if (actv !== expv) begin
      errors = errors + 1;
      $display("Error: %s expected %h actual %h", name, expv, actv);
    end
  endtask

  task automatic check_bit(input string name, input logic expv, input logic actv);
    checks = checks + 1;
    if (actv !== expv) begin
      errors = errors + 1;
      $display("Error: %s expected %b actual %b", name, expv, actv);
    end
  endtask

  task automatic write_reg(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t data);
    @(posedge clk);
    csr_wen   <= 1'b1;
    csr_waddr <= addr;
    csr_wdata <= data;
    @(posedge clk);
    csr_wen <= 1'b0;
    apply_write(addr, data);
  endtask

  task automatic read_and_check(input string name, input csr_pkg::csr_addr_t addr,
                                input csr_pkg::csr_data_t expv);
    @(posedge clk);
    csr_raddr <= addr;
    @(negedge clk);
    check_word(name, expv, csr_rdata);
  endtask

  task automatic raise_exception(input csr_pkg::csr_data_t era, input csr_pkg::ecode_t code,
                                 input csr_pkg::esubcode_t sub, input csr_pkg::csr_data_t badv);
    @(posedge clk);
    excp         <= 1'b1;
    excp_era     <= era;
    excp_code    <= code;
    excp_subcode <= sub;
    excp_addr    <= 1'b1;
    badv_addr    <= badv;
    @(posedge clk);
    excp      <= 1'b0;
    excp_addr <= 1'b0;
    take_exception(era, code, sub, badv);
  endtask

  task automatic pulse_ertn();
    @(posedge clk);
    ertn <= 1'b1;
    @(posedge clk);
    ertn <= 1'b0;
    restore_mode();
  endtask

  // tracks tval and watches the timer bit through has_int
  task automatic watch_timer(input logic periodic, input int ncycles,
                             input csr_pkg::csr_data_t first,
                             input csr_pkg::csr_data_t reload);
    csr_pkg::csr_data_t exp_tval;
    logic               fire_seen;
    exp_tval  = first;
    fire_seen = 1'b0;
    csr_raddr <= csr_pkg::TVAL;
    repeat (ncycles) begin
      @(negedge clk);
      if (fire_seen) begin
        exp_ti = 1'b1;
      end
      check_word(periodic ? "periodic tval" : "one-shot tval", exp_tval, csr_rdata);
      check_bit(periodic ? "periodic has_int" : "one-shot has_int", int_pending(), has_int);
      fire_seen = (exp_tval == 32'd0);
      if (exp_tval == csr_pkg::TIMER_OFF) begin
        exp_tval = csr_pkg::TIMER_OFF;
      end else if ((exp_tval == 32'd0) && periodic) begin
        exp_tval = reload;
      end else begin
        exp_tval = exp_tval - 32'd1;
      end
    end
  endtask

  initial begin
    logic [31:0]        rnd;
    int                 idx;
    logic [29:0]        initval;
    csr_pkg::csr_data_t start;
    logic [63:0]        t_first;
    logic [63:0]        t_second;
    int                 n;

    clk          = 1'b0;
    resetn       = 1'b0;
    csr_raddr    = '0;
    csr_wen      = 1'b0;
    csr_waddr    = '0;
    csr_wdata    = '0;
    interrupt    = '0;
    excp         = 1'b0;
    ertn         = 1'b0;
    excp_era     = '0;
    excp_code    = '0;
    excp_subcode = '0;
    excp_addr    = 1'b0;
    badv_addr    = '0;
    seed         = 32'hb619;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    clear_state();
    rw_addrs[0] = csr_pkg::CRMD;
    rw_addrs[1] = csr_pkg::PRMD;
    rw_addrs[2] = csr_pkg::ECFG;
    rw_addrs[3] = csr_pkg::ERA;
    rw_addrs[4] = csr_pkg::BADV;
    rw_addrs[5] = csr_pkg::EENTRY;
    rw_addrs[6] = csr_pkg::TID;
    for (int i = 0; i < SAVE_NUM; i++) begin
      rw_addrs[7 + i] = csr_pkg::csr_addr_t'(csr_pkg::SAVE0 + i);
    end

    repeat (8) @(posedge clk);
    resetn <= 1'b1;
    @(negedge clk);
    check_bit("has_int after reset", 1'b0, has_int);
    check_word("plv after reset", 32'd0, {30'd0, plv});
    checks = checks + 1;
    if (timer_64 !== 64'd0) begin
      errors = errors + 1;
      $display("Error: counter after reset expected 0 actual %0d", timer_64);
    end
    read_and_check("crmd after reset", csr_pkg::CRMD, expected_read(csr_pkg::CRMD));
    read_and_check("tval after reset", csr_pkg::TVAL, csr_pkg::TIMER_OFF);

    // register read and write
    for (int i = 0; i < RW_NUM; i++) begin
      write_reg(rw_addrs[i], draw_random());
    end
    repeat (RW_ROUNDS) begin
      rnd = draw_random();
      idx = int'(rnd % RW_NUM);
      write_reg(rw_addrs[idx], draw_random());
      read_and_check("written reg", rw_addrs[idx], expected_read(rw_addrs[idx]));
      rnd = draw_random();
      idx = int'(rnd % RW_NUM);
      read_and_check("random reg", rw_addrs[idx], expected_read(rw_addrs[idx]));
      read_and_check("unmapped reg", {4'hf, rnd[9:0]}, 32'd0);
    end
    check_word("eentry_out", exp_eentry, eentry_out);
    check_word("tid_out", exp_tid, tid_out);

    // exception entry and return
    repeat (4) begin
      write_reg(csr_pkg::CRMD, draw_random());
      rnd = draw_random();
      raise_exception(draw_random(), rnd[5:0], rnd[14:6], draw_random());
      @(negedge clk);
      check_word("plv after excp", {30'd0, exp_crmd[1:0]}, {30'd0, plv});
      check_word("era_out", exp_era, era_out);
      read_and_check("crmd after excp", csr_pkg::CRMD, expected_read(csr_pkg::CRMD));
      read_and_check("prmd after excp", csr_pkg::PRMD, expected_read(csr_pkg::PRMD));
      read_and_check("estat after excp", csr_pkg::ESTAT, expected_read(csr_pkg::ESTAT));
      read_and_check("badv after excp", csr_pkg::BADV, expected_read(csr_pkg::BADV));
      pulse_ertn();
      @(negedge clk);
      check_word("plv after ertn", {30'd0, exp_crmd[1:0]}, {30'd0, plv});
      read_and_check("crmd after ertn", csr_pkg::CRMD, expected_read(csr_pkg::CRMD));
    end

    // interrupt request
    repeat (INT_ROUNDS) begin
      rnd = draw_random();
      @(posedge clk);
      interrupt <= rnd[7:0];
      exp_is_hw = rnd[7:0];
      write_reg(csr_pkg::ECFG, draw_random());
      write_reg(csr_pkg::ESTAT, draw_random());
      write_reg(csr_pkg::CRMD, draw_random());
      @(negedge clk);
      check_bit("has_int", int_pending(), has_int);
      read_and_check("estat lines", csr_pkg::ESTAT, expected_read(csr_pkg::ESTAT));
    end
    @(posedge clk);
    interrupt <= '0;
    exp_is_hw = '0;

    // one-shot timer
    write_reg(csr_pkg::ESTAT, 32'd0);
    write_reg(csr_pkg::ECFG, 32'h0000_0800);
    write_reg(csr_pkg::CRMD, 32'h0000_0004);
    write_reg(csr_pkg::TICLR, 32'd1);
    rnd = draw_random();
    initval = {27'd0, rnd[2:0]} + 30'd2;
    start = {initval, 2'b00};
    write_reg(csr_pkg::TCFG, {initval, 2'b01});
    watch_timer(1'b0, int'(start) + 4, start, start);
    read_and_check("estat timer set", csr_pkg::ESTAT, expected_read(csr_pkg::ESTAT));
    write_reg(csr_pkg::TICLR, 32'd1);
    @(negedge clk);
    check_bit("has_int after ticlr", int_pending(), has_int);
    read_and_check("estat timer clear", csr_pkg::ESTAT, expected_read(csr_pkg::ESTAT));

    // periodic timer firing twice with a clear in between
    write_reg(csr_pkg::TCFG, {initval, 2'b11});
    watch_timer(1'b1, int'(start) + 2, start, start);
    write_reg(csr_pkg::TICLR, 32'd1);
    watch_timer(1'b1, int'(start) + 1, start - 32'd2, start);
    write_reg(csr_pkg::TCFG, 32'd0);
    write_reg(csr_pkg::TICLR, 32'd1);

    // stable counter
    rnd = draw_random();
    n = 5 + int'(rnd % 32'd50);
    @(negedge clk);
    t_first = timer_64;
    repeat (n) @(negedge clk);
    t_second = timer_64;
    checks = checks + 1;
    if ((t_second - t_first) !== 64'(n)) begin
      errors = errors + 1;
      $display("Error: stable counter expected %0d actual %0d", n, t_second - t_first);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* design/csr_bus_if.sv */
`timescale 1ns/100ps

interface csr_bus_if (
  input logic clk
);

  logic               wen;
  csr_pkg::csr_addr_t waddr;
  csr_pkg::csr_data_t wdata;
  csr_pkg::csr_addr_t raddr;
  logic               excp;

  // driven by the regfile top
  modport host (output wen, waddr, wdata, raddr, excp);

  // register units sample everything
  modport unit (input wen, waddr, wdata, raddr, excp);

  // read select only needs the address
  modport sel (input clk, raddr);

endinterface

/* design/csr_excp_unit.sv */
`timescale 1ns/100ps

module csr_excp_unit (
  input  logic               clk,
  input  logic               resetn,
  csr_bus_if.unit            bus,
  input  logic               ertn,
  input  csr_pkg::csr_data_t excp_era,
  input  logic               excp_addr,
  input  csr_pkg::csr_data_t badv_addr,
  output logic               crmd_ie,
  output csr_pkg::plv_t      plv,
  output csr_pkg::csr_data_t eentry_out,
  output csr_pkg::csr_data_t era_out,
  output csr_pkg::csr_data_t rdata,
  output logic               hit
);

  localparam int VA_W = 32 - csr_pkg::EENTRY_VA_LO;

  csr_pkg::plv_t      crmd_plv;
  logic               crmd_da;
  logic               crmd_pg;
  csr_pkg::plv_t      prmd_pplv;
  logic               prmd_pie;
  csr_pkg::csr_data_t era;
  csr_pkg::csr_data_t badv;
  logic [VA_W-1:0]    eentry_va;
  csr_pkg::csr_data_t crmd_val;
  csr_pkg::csr_data_t prmd_val;

  logic crmd_wen;
  logic prmd_wen;
  logic era_wen;
  logic badv_wen;
  logic eentry_wen;

  assign crmd_wen   = bus.wen && (bus.waddr == csr_pkg::CRMD);
  assign prmd_wen   = bus.wen && (bus.waddr == csr_pkg::PRMD);
  assign era_wen    = bus.wen && (bus.waddr == csr_pkg::ERA);
  assign badv_wen   = bus.wen && (bus.waddr == csr_pkg::BADV);
  assign eentry_wen = bus.wen && (bus.waddr == csr_pkg::EENTRY);

  // excp beats ertn, which beats a software write
  always_ff @(posedge clk) begin
    if (!resetn) begin
      crmd_plv <= '0;
      crmd_ie  <= 1'b0;
      crmd_da  <= csr_pkg::CRMD_DA_RESET;
      crmd_pg  <= 1'b0;
    end else if (bus.excp) begin
      crmd_plv <= '0;
      crmd_ie  <= 1'b0;
    end else if (ertn) begin
      crmd_plv <= prmd_pplv;
      crmd_ie  <= prmd_pie;
    end else if (crmd_wen) begin
      crmd_plv <= bus.wdata[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO];
      crmd_ie  <= bus.wdata[csr_pkg::CRMD_IE];
      crmd_da  <= bus.wdata[csr_pkg::CRMD_DA];
      crmd_pg  <= bus.wdata[csr_pkg::CRMD_PG];
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      prmd_pplv <= '0;
      prmd_pie  <= 1'b0;
    end else if (bus.excp) begin
      prmd_pplv <= crmd_plv;
      prmd_pie  <= crmd_ie;
    end else if (prmd_wen) begin
      prmd_pplv <= bus.wdata[csr_pkg::PRMD_PPLV_HI:csr_pkg::PRMD_PPLV_LO];
      prmd_pie  <= bus.wdata[csr_pkg::PRMD_PIE];
    end
  end

  always_ff @(posedge clk) begin
    if (bus.excp) begin
      era <= excp_era;
    end else if (era_wen) begin
      era <= bus.wdata;
    end
    // software write wins over the fault address
    if (badv_wen) begin
      badv <= bus.wdata;
    end else if (excp_addr) begin
      badv <= badv_addr;
    end
    if (eentry_wen) begin
      eentry_va <= bus.wdata[31:csr_pkg::EENTRY_VA_LO];
    end
  end

  always_comb begin
    crmd_val = '0;
    crmd_val[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO] = crmd_plv;
    crmd_val[csr_pkg::CRMD_IE] = crmd_ie;
    crmd_val[csr_pkg::CRMD_DA] = crmd_da;
    crmd_val[csr_pkg::CRMD_PG] = crmd_pg;
    prmd_val = '0;
    prmd_val[csr_pkg::PRMD_PPLV_HI:csr_pkg::PRMD_PPLV_LO] = prmd_pplv;
    prmd_val[csr_pkg::PRMD_PIE] = prmd_pie;
  end

  assign plv        = crmd_plv;
  assign era_out    = era;
  assign eentry_out = {eentry_va, {csr_pkg::EENTRY_VA_LO{1'b0}}};

  always_comb begin
    hit   = 1'b1;
    rdata = '0;
    case (bus.raddr)
      csr_pkg::CRMD:   rdata = crmd_val;
      csr_pkg::PRMD:   rdata = prmd_val;
      csr_pkg::ERA:    rdata = era;
      csr_pkg::BADV:   rdata = badv;
      csr_pkg::EENTRY: rdata = eentry_out;
      default:         hit = 1'b0;
    endcase
  end

  // the pipeline retires at most one of these per cycle
  a_excp_ertn_excl: assert property (@(posedge clk) disable iff (!resetn)
    !(bus.excp && ertn));

endmodule

/* design/csr_intr_unit.sv */
`timescale 1ns/100ps

module csr_intr_unit (
  input  logic                          clk,
  input  logic                          resetn,
  csr_bus_if.unit                       bus,
  input  logic [csr_pkg::INT_LINES-1:0] interrupt,
  input  csr_pkg::ecode_t               excp_code,
  input  csr_pkg::esubcode_t            excp_subcode,
  input  logic                          crmd_ie,
  input  logic                          timer_fire,
  output logic                          has_int,
  output csr_pkg::csr_data_t            rdata,
  output logic                          hit
);

  localparam int IS_W = csr_pkg::ESTAT_IS_HI - csr_pkg::ESTAT_IS_LO + 1;

  logic [IS_W-1:0]                 ecfg_lie;
  logic [csr_pkg::ESTAT_HW_LO-1:0] is_sw;
  logic [csr_pkg::INT_LINES-1:0]   is_hw;
  logic                            is_ti;
  csr_pkg::ecode_t                 ecode;
  csr_pkg::esubcode_t              esubcode;
  logic [IS_W-1:0]                 is_vec;
  csr_pkg::csr_data_t              estat_val;

  logic ecfg_wen;
  logic estat_wen;
  logic ticlr_wen;

  assign ecfg_wen  = bus.wen && (bus.waddr == csr_pkg::ECFG);
  assign estat_wen = bus.wen && (bus.waddr == csr_pkg::ESTAT);
  assign ticlr_wen = bus.wen && (bus.waddr == csr_pkg::TICLR);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ecfg_lie <= '0;
    end else if (ecfg_wen) begin
      ecfg_lie <= bus.wdata[IS_W-1:0] & csr_pkg::ECFG_LIE_MASK;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      is_sw    <= '0;
      is_hw    <= '0;
      is_ti    <= 1'b0;
      ecode    <= '0;
      esubcode <= '0;
    end else begin
      is_hw <= interrupt;
      // a fire in the same cycle beats the clear
      if (timer_fire) begin
        is_ti <= 1'b1;
      end else if (ticlr_wen && bus.wdata[csr_pkg::TICLR_CLR]) begin
        is_ti <= 1'b0;
      end
      if (bus.excp) begin
        ecode    <= excp_code;
        esubcode <= excp_subcode;
      end else if (estat_wen) begin
        is_sw <= bus.wdata[csr_pkg::ESTAT_HW_LO-1:0];
      end
    end
  end

  // bits 10 and 12 not implemented
  always_comb begin
    is_vec = '0;
    is_vec[csr_pkg::ESTAT_HW_LO-1:0] = is_sw;
    is_vec[csr_pkg::ESTAT_HW_LO +: csr_pkg::INT_LINES] = is_hw;
    is_vec[csr_pkg::ESTAT_TI_BIT] = is_ti;
    estat_val = '0;
    estat_val[csr_pkg::ESTAT_IS_HI:csr_pkg::ESTAT_IS_LO] = is_vec;
    estat_val[csr_pkg::ESTAT_ECODE_HI:csr_pkg::ESTAT_ECODE_LO] = ecode;
    estat_val[csr_pkg::ESTAT_SUB_HI:csr_pkg::ESTAT_SUB_LO] = esubcode;
  end

  assign has_int = crmd_ie && ((ecfg_lie & is_vec) != '0);

  always_comb begin
    hit   = 1'b1;
    rdata = '0;
    case (bus.raddr)
      csr_pkg::ECFG:  rdata = {{(32 - IS_W){1'b0}}, ecfg_lie};
      csr_pkg::ESTAT: rdata = estat_val;
      default:        hit = 1'b0;
    endcase
  end

endmodule

/* design/csr_pkg.sv */
package csr_pkg;

  typedef logic [13:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  typedef logic [5:0]  ecode_t;
  typedef logic [8:0]  esubcode_t;
  typedef logic [1:0]  plv_t;

  // register addresses
  localparam csr_addr_t CRMD   = 14'h000;
  localparam csr_addr_t PRMD   = 14'h001;
  localparam csr_addr_t ECFG   = 14'h004;
  localparam csr_addr_t ESTAT  = 14'h005;
  localparam csr_addr_t ERA    = 14'h006;
  localparam csr_addr_t BADV   = 14'h007;
  localparam csr_addr_t EENTRY = 14'h00c;
  localparam csr_addr_t SAVE0  = 14'h030;
  localparam csr_addr_t TID    = 14'h040;
  localparam csr_addr_t TCFG   = 14'h041;
  localparam csr_addr_t TVAL   = 14'h042;
  localparam csr_addr_t TICLR  = 14'h044;

  localparam int CRMD_PLV_LO = 0;
  localparam int CRMD_PLV_HI = 1;
  localparam int CRMD_IE     = 2;
  localparam int CRMD_DA     = 3;
  localparam int CRMD_PG     = 4;

  localparam int PRMD_PPLV_LO = 0;
  localparam int PRMD_PPLV_HI = 1;
  localparam int PRMD_PIE     = 2;

  localparam int ESTAT_IS_LO    = 0;
  localparam int ESTAT_IS_HI    = 12;
  localparam int ESTAT_HW_LO    = 2;
  localparam int ESTAT_TI_BIT   = 11;
  localparam int ESTAT_ECODE_LO = 16;
  localparam int ESTAT_ECODE_HI = 21;
  localparam int ESTAT_SUB_LO   = 22;
  localparam int ESTAT_SUB_HI   = 30;

  // lie bits 12:11 and 9:0
  localparam logic [12:0] ECFG_LIE_MASK = 13'h1bff;

  localparam int TCFG_EN         = 0;
  localparam int TCFG_PERIODIC   = 1;
  localparam int TCFG_INITVAL_LO = 2;
  localparam int EENTRY_VA_LO    = 6;
  localparam int TICLR_CLR       = 0;

  localparam int INT_LINES = 8;
  localparam csr_data_t TIMER_OFF = 32'hffff_ffff;
  localparam logic CRMD_DA_RESET = 1'b1;

endpackage

/* design/csr_read_mux.sv */
`timescale 1ns/100ps

module csr_read_mux (
  csr_bus_if.sel             bus,
  input  csr_pkg::csr_data_t excp_rdata,
  input  logic               excp_hit,
  input  csr_pkg::csr_data_t intr_rdata,
  input  logic               intr_hit,
  input  csr_pkg::csr_data_t timer_rdata,
  input  logic               timer_hit,
  input  csr_pkg::csr_data_t save_rdata,
  input  logic               save_hit,
  output csr_pkg::csr_data_t csr_rdata
);

  logic [3:0] hits;

  assign hits = {save_hit, timer_hit, intr_hit, excp_hit};

  // and-or select gives zero when nobody claims the address
  assign csr_rdata = ({32{excp_hit}}  & excp_rdata)  |
                     ({32{intr_hit}}  & intr_rdata)  |
                     ({32{timer_hit}} & timer_rdata) |
                     ({32{save_hit}}  & save_rdata);

  // address maps of the units must not overlap
  a_hit_onehot: assert property (@(posedge bus.clk) disable iff ($isunknown(bus.raddr))
    $onehot0(hits));

endmodule

/* design/csr_regfile.sv */
`timescale 1ns/100ps

module csr_regfile #(
  parameter int SAVE_NUM = 4
) (
  input  logic                          clk,
  input  logic                          resetn,
  input  csr_pkg::csr_addr_t            csr_raddr,
  output csr_pkg::csr_data_t            csr_rdata,
  input  logic                          csr_wen,
  input  csr_pkg::csr_addr_t            csr_waddr,
  input  csr_pkg::csr_data_t            csr_wdata,
  input  logic [csr_pkg::INT_LINES-1:0] interrupt,
  input  logic                          excp,
  input  logic                          ertn,
  input  csr_pkg::csr_data_t            excp_era,
  input  csr_pkg::ecode_t               excp_code,
  input  csr_pkg::esubcode_t            excp_subcode,
  input  logic                          excp_addr,
  input  csr_pkg::csr_data_t            badv_addr,
  output logic                          has_int,
  output csr_pkg::plv_t                 plv,
  output csr_pkg::csr_data_t            eentry_out,
  output csr_pkg::csr_data_t            era_out,
  output csr_pkg::csr_data_t            tid_out,
  output logic [63:0]                   timer_64
);

  csr_pkg::csr_data_t excp_rdata;
  csr_pkg::csr_data_t intr_rdata;
  csr_pkg::csr_data_t timer_rdata;
  csr_pkg::csr_data_t save_rdata;
  logic               excp_hit;
  logic               intr_hit;
  logic               timer_hit;
  logic               save_hit;
  logic               crmd_ie;
  logic               timer_fire;

  csr_bus_if bus (.clk(clk));

  assign bus.wen   = csr_wen;
  assign bus.waddr = csr_waddr;
  assign bus.wdata = csr_wdata;
  assign bus.raddr = csr_raddr;
  assign bus.excp  = excp;

  csr_excp_unit u_excp (
    .clk(clk), .resetn(resetn), .bus(bus.unit), .ertn(ertn),
    .excp_era(excp_era), .excp_addr(excp_addr), .badv_addr(badv_addr),
    .crmd_ie(crmd_ie), .plv(plv), .eentry_out(eentry_out), .era_out(era_out),
    .rdata(excp_rdata), .hit(excp_hit)
  );

  csr_intr_unit u_intr (
    .clk(clk), .resetn(resetn), .bus(bus.unit), .interrupt(interrupt),
    .excp_code(excp_code), .excp_subcode(excp_subcode), .crmd_ie(crmd_ie),
    .timer_fire(timer_fire), .has_int(has_int), .rdata(intr_rdata), .hit(intr_hit)
  );

  csr_timer_unit u_timer (
    .clk(clk), .resetn(resetn), .bus(bus.unit), .timer_fire(timer_fire),
    .timer_64(timer_64), .rdata(timer_rdata), .hit(timer_hit)
  );

  csr_save_unit #(.SAVE_NUM(SAVE_NUM)) u_save (
    .clk(clk), .resetn(resetn), .bus(bus.unit), .tid_out(tid_out),
    .rdata(save_rdata), .hit(save_hit)
  );

  csr_read_mux u_rmux (
    .bus(bus.sel),
    .excp_rdata(excp_rdata), .excp_hit(excp_hit),
    .intr_rdata(intr_rdata), .intr_hit(intr_hit),
    .timer_rdata(timer_rdata), .timer_hit(timer_hit),
    .save_rdata(save_rdata), .save_hit(save_hit),
    .csr_rdata(csr_rdata)
  );

endmodule

/* design/csr_save_unit.sv */
`timescale 1ns/100ps

module csr_save_unit #(
  parameter int SAVE_NUM = 4
) (
  input  logic               clk,
  input  logic               resetn,
  csr_bus_if.unit            bus,
  output csr_pkg::csr_data_t tid_out,
  output csr_pkg::csr_data_t rdata,
  output logic               hit
);

  csr_pkg::csr_data_t  save_q [SAVE_NUM];
  csr_pkg::csr_data_t  save_rd [SAVE_NUM];
  logic [SAVE_NUM-1:0] save_sel;
  logic                tid_sel;

  for (genvar i = 0; i < SAVE_NUM; i++) begin : g_save
    localparam csr_pkg::csr_addr_t ADDR = csr_pkg::csr_addr_t'(csr_pkg::SAVE0 + i);

    always_ff @(posedge clk) begin
      if (bus.wen && (bus.waddr == ADDR)) begin
        save_q[i] <= bus.wdata;
      end
    end

    assign save_sel[i] = (bus.raddr == ADDR);
    assign save_rd[i]  = save_sel[i] ? save_q[i] : '0;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      tid_out <= '0;
    end else if (bus.wen && (bus.waddr == csr_pkg::TID)) begin
      tid_out <= bus.wdata;
    end
  end

  assign tid_sel = (bus.raddr == csr_pkg::TID);
  assign hit     = (|save_sel) || tid_sel;

  always_comb begin
    rdata = tid_sel ? tid_out : '0;
    for (int i = 0; i < SAVE_NUM; i++) begin
      rdata = rdata | save_rd[i];
    end
  end

endmodule

/* design/csr_timer_unit.sv */
`timescale 1ns/100ps

module csr_timer_unit (
  input  logic               clk,
  input  logic               resetn,
  csr_bus_if.unit            bus,
  output logic               timer_fire,
  output logic [63:0]        timer_64,
  output csr_pkg::csr_data_t rdata,
  output logic               hit
);

  localparam int IV_W = 32 - csr_pkg::TCFG_INITVAL_LO;

  logic               tcfg_en;
  logic               tcfg_periodic;
  logic [IV_W-1:0]    tcfg_initval;
  csr_pkg::csr_data_t tval;
  csr_pkg::csr_data_t reload_val;
  csr_pkg::csr_data_t tcfg_val;
  logic               tcfg_wen;

  assign tcfg_wen = bus.wen && (bus.waddr == csr_pkg::TCFG);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      tcfg_en       <= 1'b0;
      tcfg_periodic <= 1'b0;
      tcfg_initval  <= '0;
    end else if (tcfg_wen) begin
      tcfg_en       <= bus.wdata[csr_pkg::TCFG_EN];
      tcfg_periodic <= bus.wdata[csr_pkg::TCFG_PERIODIC];
      tcfg_initval  <= bus.wdata[31:csr_pkg::TCFG_INITVAL_LO];
    end
  end

  assign reload_val = {tcfg_initval, {csr_pkg::TCFG_INITVAL_LO{1'b0}}};

  // one-shot runs past zero to all ones and parks there
  always_ff @(posedge clk) begin
    if (!resetn) begin
      tval <= csr_pkg::TIMER_OFF;
    end else if (tcfg_wen && bus.wdata[csr_pkg::TCFG_EN]) begin
      tval <= {bus.wdata[31:csr_pkg::TCFG_INITVAL_LO], {csr_pkg::TCFG_INITVAL_LO{1'b0}}};
    end else if (tcfg_en && (tval != csr_pkg::TIMER_OFF)) begin
      if ((tval == '0) && tcfg_periodic) begin
        tval <= reload_val;
      end else begin
        tval <= tval - 32'd1;
      end
    end
  end

  assign timer_fire = tcfg_en && (tval == '0);

  // stable counter
  always_ff @(posedge clk) begin
    if (!resetn) begin
      timer_64 <= '0;
    end else begin
      timer_64 <= timer_64 + 64'd1;
    end
  end

  always_comb begin
    tcfg_val = '0;
    tcfg_val[csr_pkg::TCFG_EN] = tcfg_en;
    tcfg_val[csr_pkg::TCFG_PERIODIC] = tcfg_periodic;
    tcfg_val[31:csr_pkg::TCFG_INITVAL_LO] = tcfg_initval;
  end

  // ticlr is write-only and reads back zero
  always_comb begin
    hit   = 1'b1;
    rdata = '0;
    case (bus.raddr)
      csr_pkg::TCFG:  rdata = tcfg_val;
      csr_pkg::TVAL:  rdata = tval;
      csr_pkg::TICLR: rdata = '0;
      default:        hit = 1'b0;
    endcase
  end

  // a one-shot timer parks at all ones right after it fires
  a_oneshot_parks: assert property (@(posedge clk) disable iff (!resetn)
    timer_fire && !tcfg_periodic && !tcfg_wen |=> tval == csr_pkg::TIMER_OFF);

endmodule

/* sim.f */
+incdir+bench
design/csr_pkg.sv
design/csr_bus_if.sv
design/csr_excp_unit.sv
design/csr_intr_unit.sv
design/csr_timer_unit.sv
design/csr_save_unit.sv
design/csr_read_mux.sv
design/csr_regfile.sv
bench/tb_csr.sv
